/* common/bp_pkg.sv */
package bp_pkg;

    // address split
    localparam int PC_WIDTH   = 32;
    localparam int ADDR_WIDTH = 8;   // 256 sets
    localparam int TAG_WIDTH  = 22;
    localparam int INDEX_LSB  = 2;
    localparam int TAG_LSB    = 10;
    localparam int SETS       = 1 << ADDR_WIDTH;

    // global history selects the counter inside an entry
    localparam int H_WIDTH = 4;
    localparam int CNT_NUM = 1 << H_WIDTH;

    // associativity
    localparam int WAYS     = 4;
    localparam int WAY_BITS = 2;

    // entry layout, low to high: counters, valid, tag
    localparam int VALID_BIT   = 2 * CNT_NUM;
    localparam int ENTRY_WIDTH = TAG_WIDTH + 1 + 2 * CNT_NUM;

    // upper bit is the predicted direction
    typedef enum logic [1:0] {
        strong_nt = 2'd0,
        weak_nt   = 2'd1,
        weak_t    = 2'd2,
        strong_t  = 2'd3
    } ctr_state_e;

endpackage

/* pred_cache/pred_ram.sv */
`timescale 1ns/1ps

module pred_ram import bp_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [ADDR_WIDTH-1:0]  raddr,
    input  logic [ADDR_WIDTH-1:0]  uaddr,
    input  logic                   we,
    input  logic [ADDR_WIDTH-1:0]  waddr,
    input  logic [ENTRY_WIDTH-1:0] wdata,
    output logic [ENTRY_WIDTH-1:0] rentry,
    output logic [ENTRY_WIDTH-1:0] uentry
);

    // tag and counters only, valid lives in flops
    logic [ENTRY_WIDTH-2:0] mem [SETS];
    logic [SETS-1:0]        valid_q;

    logic [ENTRY_WIDTH-2:0] rdata_q;
    logic [ENTRY_WIDTH-2:0] udata_q;
    logic                   rvalid_q;
    logic                   uvalid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= '0;
            rvalid_q <= 1'b0;
            uvalid_q <= 1'b0;
        end else begin
            rvalid_q <= valid_q[raddr];  // old value on a same-edge write
            uvalid_q <= valid_q[uaddr];
            if (we) begin
                valid_q[waddr] <= wdata[VALID_BIT];
            end
        end
    end

    always_ff @(posedge clk) begin
        rdata_q <= mem[raddr];
        udata_q <= mem[uaddr];
        if (we) begin
            mem[waddr] <= {wdata[ENTRY_WIDTH-1:VALID_BIT+1], wdata[VALID_BIT-1:0]};
        end
    end

    // put the valid bit back in its slot
    assign rentry = {rdata_q[ENTRY_WIDTH-2:VALID_BIT], rvalid_q, rdata_q[VALID_BIT-1:0]};
    assign uentry = {udata_q[ENTRY_WIDTH-2:VALID_BIT], uvalid_q, udata_q[VALID_BIT-1:0]};

endmodule

/* pred_cache/pred_replace.sv */
`timescale 1ns/1ps

module pred_replace import bp_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic                  alloc,
    output logic [WAY_BITS-1:0]   victim
);

    // one round-robin pointer per set
    logic [WAY_BITS-1:0] ptr_q [SETS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                ptr_q[s] <= '0;
            end
        end else if (alloc) begin
            ptr_q[addr] <= ptr_q[addr] + 1'b1;  // wraps at WAYS
        end
    end

    assign victim = ptr_q[addr];

endmodule

/* pred_cache/pred_cache.sv */
`timescale 1ns/1ps

module pred_cache import bp_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  lookup_en,
    input  logic [ADDR_WIDTH-1:0] lookup_set,
    input  logic [TAG_WIDTH-1:0]  lookup_tag,
    input  logic [H_WIDTH-1:0]    lookup_hist,
    input  logic                  update_en,
    input  logic [ADDR_WIDTH-1:0] update_set,
    input  logic [TAG_WIDTH-1:0]  update_tag,
    input  logic [H_WIDTH-1:0]    update_hist,
    input  logic                  update_taken,
    output logic                  pred_valid,
    output logic                  pred_taken,
    output logic                  pred_hit
);

    // saturating 2-bit step
    function automatic ctr_state_e ctr_next(input ctr_state_e cur, input logic taken);
        ctr_state_e nxt;
        case (cur)
            strong_nt: nxt = taken ? weak_nt  : strong_nt;
            weak_nt:   nxt = taken ? weak_t   : strong_nt;
            weak_t:    nxt = taken ? strong_t : weak_nt;
            default:   nxt = taken ? strong_t : weak_t;
        endcase
        return nxt;
    endfunction

    logic [WAYS-1:0][ENTRY_WIDTH-1:0] rentry;
    logic [WAYS-1:0][ENTRY_WIDTH-1:0] uentry;
    logic [WAYS-1:0]                  way_we;
    logic [ENTRY_WIDTH-1:0]           wdata;

    // lookup stage
    logic                  lk_en_q;
    logic [TAG_WIDTH-1:0]  lk_tag_q;
    logic [H_WIDTH-1:0]    lk_hist_q;
    logic                  lk_hit;
    ctr_state_e            lk_ctr;

    // update stage
    logic                  upd_en_q;
    logic                  upd_taken_q;
    logic [ADDR_WIDTH-1:0] upd_set_q;
    logic [TAG_WIDTH-1:0]  upd_tag_q;
    logic [H_WIDTH-1:0]    upd_hist_q;
    logic                  match_found;
    logic                  free_found;
    logic [WAY_BITS-1:0]   match_way;
    logic [WAY_BITS-1:0]   free_way;
    logic [WAY_BITS-1:0]   victim;
    logic [WAY_BITS-1:0]   wr_way;
    logic                  alloc;
    logic [ENTRY_WIDTH-1:0] base_entry;
    ctr_state_e            old_ctr;
    ctr_state_e            new_ctr;

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        pred_ram u_ram (
            .clk    (clk),
            .rst_n  (rst_n),
            .raddr  (lookup_set),
            .uaddr  (update_set),
            .we     (way_we[w]),
            .waddr  (upd_set_q),
            .wdata  (wdata),
            .rentry (rentry[w]),
            .uentry (uentry[w])
        );
    end

    pred_replace u_replace (
        .clk    (clk),
        .rst_n  (rst_n),
        .addr   (upd_set_q),
        .alloc  (alloc),
        .victim (victim)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lk_en_q  <= 1'b0;
            upd_en_q <= 1'b0;
        end else begin
            lk_en_q  <= lookup_en;
            upd_en_q <= update_en;
        end
    end

    always_ff @(posedge clk) begin
        lk_tag_q    <= lookup_tag;
        lk_hist_q   <= lookup_hist;
        upd_set_q   <= update_set;
        upd_tag_q   <= update_tag;
        upd_hist_q  <= update_hist;  // history before the shift
        upd_taken_q <= update_taken;
    end

    // walk down so the lowest matching way wins
    always_comb begin
        lk_hit = 1'b0;
        lk_ctr = strong_nt;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (rentry[w][VALID_BIT] &&
                rentry[w][VALID_BIT+1 +: TAG_WIDTH] == lk_tag_q) begin
                lk_hit = 1'b1;
                lk_ctr = ctr_state_e'(rentry[w][2*lk_hist_q +: 2]);
            end
        end
    end

    assign pred_valid = lk_en_q;
    assign pred_hit   = lk_en_q & lk_hit;
    assign pred_taken = pred_hit & lk_ctr[1];  // miss predicts not taken

    always_comb begin
        match_found = 1'b0;
        match_way   = '0;
        free_found  = 1'b0;
        free_way    = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (uentry[w][VALID_BIT] &&
                uentry[w][VALID_BIT+1 +: TAG_WIDTH] == upd_tag_q) begin
                match_found = 1'b1;
                match_way   = WAY_BITS'(w);
            end
            if (!uentry[w][VALID_BIT]) begin
                free_found = 1'b1;
                free_way   = WAY_BITS'(w);
            end
        end
    end

    // hit, then free way, then round-robin victim
    assign wr_way = match_found ? match_way : (free_found ? free_way : victim);
    assign alloc  = upd_en_q & ~match_found & ~free_found;

    always_comb begin
        if (match_found) begin
            base_entry = uentry[match_way];
        end else begin
            base_entry = {upd_tag_q, 1'b1, {CNT_NUM{strong_nt}}};  // fresh entry
        end
        old_ctr = ctr_state_e'(base_entry[2*upd_hist_q +: 2]);
        new_ctr = ctr_next(old_ctr, upd_taken_q);
        wdata   = base_entry;
        wdata[2*upd_hist_q +: 2] = new_ctr;
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            way_we[w] = upd_en_q && (wr_way == WAY_BITS'(w));
        end
    end

endmodule

/* logic/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor import bp_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                lookup_en,
    input  logic [PC_WIDTH-1:0] lookup_pc,
    output logic                pred_valid,
    output logic                pred_taken,
    output logic                pred_hit,
    input  logic                update_en,
    input  logic [PC_WIDTH-1:0] update_pc,
    input  logic                update_taken
);

    logic [H_WIDTH-1:0] hist_q;  // global branch history

    // newest outcome enters at bit 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hist_q <= '0;
        end else if (update_en) begin
            hist_q <= {hist_q[H_WIDTH-2:0], update_taken};
        end
    end

    pred_cache u_cache (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_en    (lookup_en),
        .lookup_set   (lookup_pc[INDEX_LSB +: ADDR_WIDTH]),
        .lookup_tag   (lookup_pc[TAG_LSB +: TAG_WIDTH]),
        .lookup_hist  (hist_q),
        .update_en    (update_en),
        .update_set   (update_pc[INDEX_LSB +: ADDR_WIDTH]),
        .update_tag   (update_pc[TAG_LSB +: TAG_WIDTH]),
        .update_hist  (hist_q),
        .update_taken (update_taken),
        .pred_valid   (pred_valid),
        .pred_taken   (pred_taken),
        .pred_hit     (pred_hit)
    );

endmodule

/* verif/tb_pred_model.svh */
`ifndef TB_PRED_MODEL_SVH
`define TB_PRED_MODEL_SVH

// reference copy of every set and way
logic [TAG_WIDTH-1:0] m_tag   [SETS][WAYS];
logic                 m_valid [SETS][WAYS];
logic [1:0]           m_ctr   [SETS][WAYS][CNT_NUM];
logic [WAY_BITS-1:0]  m_ptr   [SETS];
logic [H_WIDTH-1:0]   m_hist;

function automatic void model_clear();
    for (int s = 0; s < SETS; s++) begin
        m_ptr[s] = '0;
        for (int w = 0; w < WAYS; w++) begin
            m_valid[s][w] = 1'b0;
        end
    end
    m_hist = '0;
endfunction

// result packed as {hit, taken}
function automatic logic [1:0] ref_predict(input logic [PC_WIDTH-1:0] pc,
                                           input logic [H_WIDTH-1:0] hist);
    logic [ADDR_WIDTH-1:0] set;
    logic [TAG_WIDTH-1:0]  tag;
    logic [1:0]            res;
    set = pc[INDEX_LSB +: ADDR_WIDTH];
    tag = pc[TAG_LSB +: TAG_WIDTH];
    res = 2'b00;
    for (int w = 0; w < WAYS; w++) begin
        if (!res[1] && m_valid[set][w] && m_tag[set][w] == tag) begin
            res = {1'b1, m_ctr[set][w][hist][1]};  // first match wins
        end
    end
    return res;
endfunction

function automatic void ref_update(input logic [PC_WIDTH-1:0] pc,
                                   input logic [H_WIDTH-1:0] hist,
                                   input logic taken);
    logic [ADDR_WIDTH-1:0] set;
    logic [TAG_WIDTH-1:0]  tag;
    logic [1:0]            c;
    int                    way;
    set = pc[INDEX_LSB +: ADDR_WIDTH];
    tag = pc[TAG_LSB +: TAG_WIDTH];
    way = -1;
    for (int w = 0; w < WAYS; w++) begin
        if (way < 0 && m_valid[set][w] && m_tag[set][w] == tag) begin
            way = w;
        end
    end
    if (way < 0) begin
        for (int w = 0; w < WAYS; w++) begin
            if (way < 0 && !m_valid[set][w]) begin
                way = w;
            end
        end
        if (way < 0) begin
            way = m_ptr[set];  // set full, take the round-robin victim
            m_ptr[set] = m_ptr[set] + 1'b1;
        end
        m_tag[set][way]   = tag;
        m_valid[set][way] = 1'b1;
        for (int h = 0; h < CNT_NUM; h++) begin
            m_ctr[set][way][h] = 2'd0;
        end
    end
    c = m_ctr[set][way][hist];
    if (taken && c != 2'd3) begin
        c = c + 1'b1;
    end else if (!taken && c != 2'd0) begin
        c = c - 1'b1;
    end
    m_ctr[set][way][hist] = c;
endfunction

`endif

/* verif/tb_branch_predictor.sv */
`timescale 1ns/1ps

module tb_branch_predictor import bp_pkg::*; ();

    logic                clk;
    logic                rst_n;
    logic                lookup_en;
    logic [PC_WIDTH-1:0] lookup_pc;
    logic                pred_valid;
    logic                pred_taken;
    logic                pred_hit;
    logic                update_en;
    logic [PC_WIDTH-1:0] update_pc;
    logic                update_taken;

    int                  errors;
    int                  checked;
    integer              seed;
    logic [1:0]          exp_q [$];  // {hit, taken} per sampled lookup
    logic [PC_WIDTH-1:0] pool [10];

    // update sampled last cycle, written by the DUT one edge later
    logic                pend_up;
    logic [PC_WIDTH-1:0] pend_pc;
    logic [H_WIDTH-1:0]  pend_hist;
    logic                pend_taken;

    localparam logic [PC_WIDTH-1:0] HIST_PC = 32'h0000_0ff0;  // set 0xfc
    localparam logic [PC_WIDTH-1:0] PC_A    = 32'h0040_1000;  // set 0x00

    `include "tb_pred_model.svh"

    branch_predictor uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_en    (lookup_en),
        .lookup_pc    (lookup_pc),
        .pred_valid   (pred_valid),
        .pred_taken   (pred_taken),
        .pred_hit     (pred_hit),
        .update_en    (update_en),
        .update_pc    (update_pc),
        .update_taken (update_taken)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input logic [1:0] got, input logic [1:0] exp, input string msg);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, got %b expected %b", $time, msg, got, exp);
            errors++;
        end
    endtask

    // one clock of stimulus, model kept in step with the DUT
    task automatic drive_cycle(input logic lk, input logic [PC_WIDTH-1:0] lpc,
                               input logic up, input logic [PC_WIDTH-1:0] upc,
                               input logic ut);
        @(posedge clk);
        #1;
        if (lk) begin
            exp_q.push_back(ref_predict(lpc, m_hist));  // before the pending write
        end
        if (pend_up) begin
            ref_update(pend_pc, pend_hist, pend_taken);
            pend_up = 1'b0;
        end
        if (up) begin
            pend_up    = 1'b1;
            pend_pc    = upc;
            pend_hist  = m_hist;
            pend_taken = ut;
            m_hist     = {m_hist[H_WIDTH-2:0], ut};
        end
        lookup_en    = lk;
        lookup_pc    = lpc;
        update_en    = up;
        update_pc    = upc;
        update_taken = ut;
    endtask

    task automatic do_lookup(input logic [PC_WIDTH-1:0] pc, input logic [1:0] rule);
        check_value(ref_predict(pc, m_hist), rule, "model disagrees with directed rule");
        drive_cycle(1'b1, pc, 1'b0, '0, 1'b0);
    endtask

    task automatic do_update(input logic [PC_WIDTH-1:0] pc, input logic taken);
        drive_cycle(1'b0, '0, 1'b1, pc, taken);
        drive_cycle(1'b0, '0, 1'b0, '0, 1'b0);  // keep updates two cycles apart
    endtask

    task automatic set_history(input logic [H_WIDTH-1:0] h);
        for (int b = H_WIDTH - 1; b >= 0; b--) begin
            do_update(HIST_PC, h[b]);
        end
    endtask

    task automatic train(input logic [PC_WIDTH-1:0] pc, input logic [H_WIDTH-1:0] h,
                         input logic taken, input logic [1:0] rule);
        set_history(h);
        do_update(pc, taken);
        set_history(h);
        do_lookup(pc, rule);
    endtask

    function automatic logic [PC_WIDTH-1:0] pc_in_set(input int tag);
        return {tag[TAG_WIDTH-1:0], 8'h20, 2'b00};
    endfunction

    // compare process, outputs are stable at the falling edge
    initial begin
        logic [1:0] exp;
        logic       lk_sampled;
        forever begin
            @(posedge clk);
            lk_sampled = rst_n && lookup_en;  // what the DUT sees at this edge
            @(negedge clk);
            check_value({1'b0, pred_valid}, {1'b0, lk_sampled},
                        "pred_valid one cycle after the lookup");
            if (rst_n && pred_valid) begin
                if (exp_q.size() == 0) begin
                    $display("prediction at %0t with no lookup outstanding", $time);
                    errors++;
                end else begin
                    exp = exp_q.pop_front();
                    check_value({pred_hit, pred_taken}, exp, "prediction {hit, taken}");
                    checked++;
                end
            end
        end
    end

    initial begin
        logic [31:0]         r;
        logic [PC_WIDTH-1:0] lk_pc;
        logic                up;
        int                  gap;
        int                  waits;
        errors = 0;
        checked = 0;
        seed = 32'h4f95;
        pend_up = 1'b0;
        rst_n = 1'b0;
        lookup_en = 1'b0;
        lookup_pc = '0;
        update_en = 1'b0;
        update_pc = '0;
        update_taken = 1'b0;
        model_clear();
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        do_lookup(32'h1234_5678, 2'b00);  // empty after reset
        do_lookup(32'hdead_beef, 2'b00);

        train(PC_A, 4'b0101, 1'b1, 2'b10);  // weak_nt
        train(PC_A, 4'b0101, 1'b1, 2'b11);  // weak_t
        train(PC_A, 4'b0101, 1'b1, 2'b11);  // strong_t
        set_history(4'b1010);
        do_lookup(PC_A, 2'b10);  // other counters untouched
        set_history(4'b0000);
        do_lookup(PC_A, 2'b10);
        train(PC_A, 4'b0101, 1'b0, 2'b11);
        train(PC_A, 4'b0101, 1'b0, 2'b10);
        train(PC_A, 4'b0101, 1'b0, 2'b10);
        train(PC_A, 4'b0101, 1'b0, 2'b10);  // saturated
        train(PC_A, 4'b0101, 1'b1, 2'b10);

        // five tags into one set
        for (int t = 1; t <= 5; t++) begin
            do_update(pc_in_set(t), 1'b0);
        end
        do_lookup(pc_in_set(1), 2'b00);
        for (int t = 2; t <= 5; t++) begin
            do_lookup(pc_in_set(t), 2'b10);
        end
        do_update(pc_in_set(6), 1'b0);  // victim moves on to way 1
        do_lookup(pc_in_set(2), 2'b00);
        do_lookup(pc_in_set(3), 2'b10);
        do_lookup(pc_in_set(6), 2'b10);

        for (int i = 0; i < 10; i++) begin
            r = $random(seed);
            pool[i] = {r[31:10], 7'h30, i[0], 2'b00};  // five pcs per set
        end
        gap = 1;
        for (int n = 0; n < 4000; n++) begin
            r = $random(seed);
            lk_pc = r[3] ? {r[31:12], 12'h0a4} : pool[r[7:4] % 10];
            up = (gap != 0) && r[2];
            drive_cycle(r[0] | r[1], lk_pc, up, pool[r[11:8] % 10], r[12]);
            gap = up ? 0 : gap + 1;
        end
        drive_cycle(1'b0, '0, 1'b0, '0, 1'b0);

        waits = 0;
        while (exp_q.size() != 0 && waits < 20) begin
            @(posedge clk);
            waits++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d expected predictions never arrived", exp_q.size());
            errors++;
        end

        $display("summary: %0d errors, %0d predictions checked", errors, checked);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+verif
common/bp_pkg.sv
pred_cache/pred_ram.sv
pred_cache/pred_replace.sv
pred_cache/pred_cache.sv
logic/branch_predictor.sv
verif/tb_branch_predictor.sv

/* Bender.yml */
package:
  name: branch_predictor

sources:
  - common/bp_pkg.sv
  - pred_cache/pred_ram.sv
  - pred_cache/pred_replace.sv
  - pred_cache/pred_cache.sv
  - logic/branch_predictor.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_branch_predictor.sv
